//--- logic/bru_pkg.sv
package bru_pkg;

    // Widths with a meaning of their own
    typedef logic [63:0] pc_t;       // Program counter or branch target
    typedef logic [25:0] imm_t;      // Signed word offset
    typedef logic [3:0]  cond_t;     // ARM condition field
    typedef logic [3:0]  nzcv_t;     // N=0 Z=1 C=2 V=3
    typedef logic [6:0]  phys_reg_t; // Physical register index
    typedef logic [1:0]  br_op_t;    // Branch micro-op kind

    // Branch opcodes
    localparam br_op_t OP_B     = 2'd0;
    localparam br_op_t OP_BCOND = 2'd1;
    localparam br_op_t OP_BL    = 2'd2;

    // Condition codes handled by the resolver
    localparam cond_t COND_EQ = 4'b0000;
    localparam cond_t COND_NE = 4'b0001;
    localparam cond_t COND_GE = 4'b1010;
    localparam cond_t COND_LT = 4'b1011;
    localparam cond_t COND_GT = 4'b1100;
    localparam cond_t COND_LE = 4'b1101;
    localparam cond_t COND_AL = 4'b1110;

    // Issue queue sizing
    localparam int IQ_DEPTH = 4;
    localparam int IQ_PTR_W = $clog2(IQ_DEPTH);
    localparam int IQ_CNT_W = $clog2(IQ_DEPTH + 1);

    // Return address distance for BL
    localparam pc_t LINK_OFFSET = 64'd4;

    // Output buffer word holds taken, target, mispredict, redirect, wb_en, wb_reg and wb_data
    localparam int RES_W = 3 + 3 * $bits(pc_t) + $bits(phys_reg_t);

endpackage

//--- logic/branch_issue_queue.sv
`timescale 1ns/1ps

module branch_issue_queue import bru_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,

    // Dispatch side
    input  logic      in_valid,
    output logic      in_ready,
    input  br_op_t    in_op,
    input  pc_t       in_pc,
    input  imm_t      in_imm,
    input  cond_t     in_cond,
    input  nzcv_t     in_flags,
    input  logic      in_pred_taken,
    input  phys_reg_t in_dest,

    // Head towards the resolver
    input  logic      pop,
    output logic      head_valid,
    output br_op_t    head_op,
    output pc_t       head_pc,
    output imm_t      head_imm,
    output cond_t     head_cond,
    output nzcv_t     head_flags,
    output logic      head_pred_taken,
    output phys_reg_t head_dest
);

    // Entry storage
    br_op_t    op_q    [IQ_DEPTH];
    pc_t       pc_q    [IQ_DEPTH];
    imm_t      imm_q   [IQ_DEPTH];
    cond_t     cond_q  [IQ_DEPTH];
    nzcv_t     flags_q [IQ_DEPTH];
    logic      pred_q  [IQ_DEPTH];
    phys_reg_t dest_q  [IQ_DEPTH];

    logic [IQ_PTR_W-1:0] wr_ptr;
    logic [IQ_PTR_W-1:0] rd_ptr;
    logic [IQ_CNT_W-1:0] count;
    logic                push;
    logic                do_pop;

    assign in_ready   = (count < IQ_CNT_W'(IQ_DEPTH));
    assign head_valid = (count != '0);
    assign push       = in_valid & in_ready;
    assign do_pop     = pop & head_valid; // Ignore a pop on an empty queue

    // Depth is a power of two so the pointers wrap on their own
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            if (push && !do_pop)
                count <= count + 1'b1;
            else if (!push && do_pop)
                count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            op_q[wr_ptr]    <= in_op;
            pc_q[wr_ptr]    <= in_pc;
            imm_q[wr_ptr]   <= in_imm;
            cond_q[wr_ptr]  <= in_cond;
            flags_q[wr_ptr] <= in_flags;
            pred_q[wr_ptr]  <= in_pred_taken;
            dest_q[wr_ptr]  <= in_dest;
        end
    end

    // Head read straight out of storage
    assign head_op         = op_q[rd_ptr];
    assign head_pc         = pc_q[rd_ptr];
    assign head_imm        = imm_q[rd_ptr];
    assign head_cond       = cond_q[rd_ptr];
    assign head_flags      = flags_q[rd_ptr];
    assign head_pred_taken = pred_q[rd_ptr];
    assign head_dest       = dest_q[rd_ptr];

endmodule

//--- logic/branch_resolve.sv
`timescale 1ns/1ps

module branch_resolve import bru_pkg::*; (
    // Queue head
    input  logic      head_valid,
    input  br_op_t    head_op,
    input  pc_t       head_pc,
    input  imm_t      head_imm,
    input  cond_t     head_cond,
    input  nzcv_t     head_flags,
    input  logic      head_pred_taken,
    input  phys_reg_t head_dest,

    // Result buffer has room
    input  logic      buf_ready,

    output logic      pop,
    output logic      rs_valid,
    output logic      rs_taken,
    output pc_t       rs_target,
    output logic      rs_mispredict,
    output pc_t       rs_redirect_pc,
    output logic      rs_wb_en,
    output phys_reg_t rs_wb_reg,
    output pc_t       rs_wb_data
);

    pc_t  offset;
    pc_t  link_pc;
    logic taken;

    // Flags as captured at dispatch
    function automatic logic cond_passed(input cond_t cond, input nzcv_t flags);
        logic n;
        logic z;
        logic v;
        n = flags[0];
        z = flags[1];
        v = flags[3];
        case (cond)
            COND_EQ: return z;
            COND_NE: return ~z;
            COND_GE: return ~(n ^ v);
            COND_LT: return n ^ v;
            COND_GT: return ~z & ~(n ^ v);
            COND_LE: return z | (n ^ v);
            COND_AL: return 1'b1;
            default: return 1'b0; // Anything else falls through
        endcase
    endfunction

    // Head leaves only when the buffer can take its result
    assign pop      = head_valid & buf_ready;
    assign rs_valid = pop;

    // Sign extend the word offset and scale to bytes
    assign offset  = {{($bits(pc_t) - $bits(imm_t) - 2){head_imm[$bits(imm_t)-1]}},
                      head_imm, 2'b00};
    assign link_pc = head_pc + LINK_OFFSET;

    always_comb begin
        case (head_op)
            OP_B, OP_BL: taken = 1'b1;
            OP_BCOND:    taken = cond_passed(head_cond, head_flags);
            default:     taken = 1'b0;
        endcase
    end

    assign rs_taken       = taken;
    assign rs_target      = head_pc + offset;
    assign rs_mispredict  = taken ^ head_pred_taken;
    assign rs_redirect_pc = taken ? rs_target : link_pc; // Fall through when not taken

    // Only BL writes its return address
    assign rs_wb_en   = (head_op == OP_BL);
    assign rs_wb_reg  = head_dest;
    assign rs_wb_data = link_pc;

endmodule

//--- logic/branch_result_buffer.sv
`timescale 1ns/1ps

module branch_result_buffer import bru_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,

    // From the resolver
    input  logic      rs_valid,
    input  logic      rs_taken,
    input  pc_t       rs_target,
    input  logic      rs_mispredict,
    input  pc_t       rs_redirect_pc,
    input  logic      rs_wb_en,
    input  phys_reg_t rs_wb_reg,
    input  pc_t       rs_wb_data,
    output logic      buf_ready,

    // Towards the consumer
    input  logic      res_ready,
    output logic      res_valid,
    output logic      res_taken,
    output pc_t       res_target,
    output logic      res_mispredict,
    output pc_t       res_redirect_pc,
    output logic      res_wb_en,
    output phys_reg_t res_wb_reg,
    output pc_t       res_wb_data
);

    logic [RES_W-1:0] in_word;
    logic [RES_W-1:0] main_word;
    logic [RES_W-1:0] spill_word;
    logic             main_valid;
    logic             spill_valid;
    logic             main_free;

    assign in_word = {rs_taken, rs_target, rs_mispredict, rs_redirect_pc,
                      rs_wb_en, rs_wb_reg, rs_wb_data};

    // Main slot empties this cycle or is already empty
    assign main_free = ~main_valid | res_ready;
    assign buf_ready = ~spill_valid;   // Straight from a flop

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            main_valid  <= 1'b0;
            spill_valid <= 1'b0;
        end else if (main_free) begin
            // Spill is older, so it goes first
            main_valid  <= spill_valid | rs_valid;
            spill_valid <= 1'b0;
        end else if (rs_valid) begin
            spill_valid <= 1'b1; // Park it while the output stalls
        end
    end

    always_ff @(posedge clk) begin
        if (main_free) begin
            main_word <= spill_valid ? spill_word : in_word;
        end else if (rs_valid) begin
            spill_word <= in_word;
        end
    end

    assign res_valid = main_valid;
    assign {res_taken, res_target, res_mispredict, res_redirect_pc,
            res_wb_en, res_wb_reg, res_wb_data} = main_word;

endmodule

//--- logic/branch_unit_top.sv
`timescale 1ns/1ps

module branch_unit_top import bru_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,

    // Dispatch
    input  logic      in_valid,
    output logic      in_ready,
    input  br_op_t    in_op,
    input  pc_t       in_pc,
    input  imm_t      in_imm,
    input  cond_t     in_cond,
    input  nzcv_t     in_flags,
    input  logic      in_pred_taken,
    input  phys_reg_t in_dest,

    // Resolved branches
    input  logic      res_ready,
    output logic      res_valid,
    output logic      res_taken,
    output pc_t       res_target,
    output logic      res_mispredict,
    output pc_t       res_redirect_pc,
    output logic      res_wb_en,
    output phys_reg_t res_wb_reg,
    output pc_t       res_wb_data
);

    // Queue head
    logic      head_valid;
    br_op_t    head_op;
    pc_t       head_pc;
    imm_t      head_imm;
    cond_t     head_cond;
    nzcv_t     head_flags;
    logic      head_pred_taken;
    phys_reg_t head_dest;
    logic      pop;

    // Resolver output
    logic      rs_valid;
    logic      rs_taken;
    pc_t       rs_target;
    logic      rs_mispredict;
    pc_t       rs_redirect_pc;
    logic      rs_wb_en;
    phys_reg_t rs_wb_reg;
    pc_t       rs_wb_data;
    logic      buf_ready;

    branch_issue_queue u_queue (
        .clk             (clk),
        .rst_n           (rst_n),
        .in_valid        (in_valid),
        .in_ready        (in_ready),
        .in_op           (in_op),
        .in_pc           (in_pc),
        .in_imm          (in_imm),
        .in_cond         (in_cond),
        .in_flags        (in_flags),
        .in_pred_taken   (in_pred_taken),
        .in_dest         (in_dest),
        .pop             (pop),
        .head_valid      (head_valid),
        .head_op         (head_op),
        .head_pc         (head_pc),
        .head_imm        (head_imm),
        .head_cond       (head_cond),
        .head_flags      (head_flags),
        .head_pred_taken (head_pred_taken),
        .head_dest       (head_dest)
    );

    branch_resolve u_resolve (
        .head_valid      (head_valid),
        .head_op         (head_op),
        .head_pc         (head_pc),
        .head_imm        (head_imm),
        .head_cond       (head_cond),
        .head_flags      (head_flags),
        .head_pred_taken (head_pred_taken),
        .head_dest       (head_dest),
        .buf_ready       (buf_ready),
        .pop             (pop),
        .rs_valid        (rs_valid),
        .rs_taken        (rs_taken),
        .rs_target       (rs_target),
        .rs_mispredict   (rs_mispredict),
        .rs_redirect_pc  (rs_redirect_pc),
        .rs_wb_en        (rs_wb_en),
        .rs_wb_reg       (rs_wb_reg),
        .rs_wb_data      (rs_wb_data)
    );

    branch_result_buffer u_buffer (
        .clk             (clk),
        .rst_n           (rst_n),
        .rs_valid        (rs_valid),
        .rs_taken        (rs_taken),
        .rs_target       (rs_target),
        .rs_mispredict   (rs_mispredict),
        .rs_redirect_pc  (rs_redirect_pc),
        .rs_wb_en        (rs_wb_en),
        .rs_wb_reg       (rs_wb_reg),
        .rs_wb_data      (rs_wb_data),
        .buf_ready       (buf_ready),
        .res_ready       (res_ready),
        .res_valid       (res_valid),
        .res_taken       (res_taken),
        .res_target      (res_target),
        .res_mispredict  (res_mispredict),
        .res_redirect_pc (res_redirect_pc),
        .res_wb_en       (res_wb_en),
        .res_wb_reg      (res_wb_reg),
        .res_wb_data     (res_wb_data)
    );

endmodule

//--- tb/tb_branch_unit.sv
`timescale 1ns/1ps

module tb_branch_unit import bru_pkg::*; ();

    localparam int N_RANDOM  = 200;
    localparam int TOTAL_OPS = 16 * 16 + 8 + 4 + 2 * N_RANDOM;

    typedef struct packed {
        logic      taken;
        pc_t       target;
        logic      mispredict;
        pc_t       redirect_pc;
        logic      wb_en;
        phys_reg_t wb_reg;
        pc_t       wb_data;
    } exp_res_t;

    logic      clk = 1'b0;
    logic      rst_n;
    logic      in_valid;
    logic      in_ready;
    br_op_t    in_op;
    pc_t       in_pc;
    imm_t      in_imm;
    cond_t     in_cond;
    nzcv_t     in_flags;
    logic      in_pred_taken;
    phys_reg_t in_dest;
    logic      res_ready;
    logic      res_valid;
    logic      res_taken;
    pc_t       res_target;
    logic      res_mispredict;
    pc_t       res_redirect_pc;
    logic      res_wb_en;
    phys_reg_t res_wb_reg;
    pc_t       res_wb_data;

    exp_res_t  exp_q[$];      // Scoreboard with the oldest result first
    string     test_name = "reset";
    integer    seed = 65700;
    int        errors = 0;    // Field mismatches seen by the monitor
    int        flow_errors = 0;
    int        checked = 0;
    logic      stall_mode = 1'b0;
    logic      saw_full = 1'b0;

    always #10 clk = ~clk;

    branch_unit_top u_branch_unit_top (
        .clk             (clk),
        .rst_n           (rst_n),
        .in_valid        (in_valid),
        .in_ready        (in_ready),
        .in_op           (in_op),
        .in_pc           (in_pc),
        .in_imm          (in_imm),
        .in_cond         (in_cond),
        .in_flags        (in_flags),
        .in_pred_taken   (in_pred_taken),
        .in_dest         (in_dest),
        .res_ready       (res_ready),
        .res_valid       (res_valid),
        .res_taken       (res_taken),
        .res_target      (res_target),
        .res_mispredict  (res_mispredict),
        .res_redirect_pc (res_redirect_pc),
        .res_wb_en       (res_wb_en),
        .res_wb_reg      (res_wb_reg),
        .res_wb_data     (res_wb_data)
    );

    // Expected result of one branch micro-op
    function automatic exp_res_t ref_resolve(input br_op_t op, input pc_t pc, input imm_t imm,
            input cond_t cond, input nzcv_t flags, input logic pred, input phys_reg_t dest);
        exp_res_t r;
        logic     n;
        logic     z;
        logic     v;
        logic     pass;
        longint   off;
        n = flags[0];
        z = flags[1];
        v = flags[3];
        case (cond)
            COND_EQ: pass = z;
            COND_NE: pass = !z;
            COND_GE: pass = (n == v);
            COND_LT: pass = (n != v);
            COND_GT: pass = !z && (n == v);
            COND_LE: pass = z || (n != v);
            COND_AL: pass = 1'b1;
            default: pass = 1'b0;
        endcase
        off           = longint'($signed(imm)) * 4; // Word offset in bytes
        r.taken       = (op == OP_B || op == OP_BL) ? 1'b1 : (op == OP_BCOND) && pass;
        r.target      = pc + pc_t'(off);
        r.mispredict  = (r.taken != pred);
        r.redirect_pc = r.taken ? r.target : pc + 64'd4;
        r.wb_en       = (op == OP_BL);
        r.wb_reg      = dest;
        r.wb_data     = pc + 64'd4;
        return r;
    endfunction

    task automatic check_pc(input string name, input pc_t expected, input pc_t actual);
        if (actual !== expected) begin
            $display("ERR %s expected %h actual %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_reg(input string name, input phys_reg_t expected,
            input phys_reg_t actual);
        if (actual !== expected) begin
            $display("ERR %s expected %0d actual %0d", name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("ERR %s expected %b actual %b", name, expected, actual);
            errors++;
        end
    endtask

    // Record every accepted micro-op
    always @(posedge clk) begin
        if (rst_n && in_valid && in_ready)
            exp_q.push_back(ref_resolve(in_op, in_pc, in_imm, in_cond, in_flags,
                                        in_pred_taken, in_dest));
    end

    always @(posedge clk) begin : monitor
        exp_res_t e;
        if (rst_n && res_valid && res_ready) begin
            if (exp_q.size() == 0) begin
                $display("Result with target %h came out with nothing outstanding",
                         res_target);
                errors++;
            end else begin
                e = exp_q.pop_front();
                check_bit({test_name, " taken"}, e.taken, res_taken);
                check_pc({test_name, " target"}, e.target, res_target);
                check_bit({test_name, " mispredict"}, e.mispredict, res_mispredict);
                check_pc({test_name, " redirect"}, e.redirect_pc, res_redirect_pc);
                check_bit({test_name, " wb_en"}, e.wb_en, res_wb_en);
                if (e.wb_en) begin // Register and data only matter for BL
                    check_reg({test_name, " wb_reg"}, e.wb_reg, res_wb_reg);
                    check_pc({test_name, " wb_data"}, e.wb_data, res_wb_data);
                end
                checked++;
            end
        end
    end

    initial begin : watchdog
        repeat (TOTAL_OPS * 40 + 200) @(posedge clk);
        $display("Timeout, the unit stopped accepting or returning branches");
        $display("SOME TESTS FAILED");
        $finish;
    end

    task automatic next_cycle();
        @(negedge clk);
        if (stall_mode)
            res_ready = ($random(seed) & 3) == 0; // Mostly stalled
        else
            res_ready = 1'b1;
    endtask

    // Called just after a falling edge and returns at the falling edge after acceptance
    task automatic send(input br_op_t op, input pc_t pc, input imm_t imm, input cond_t cond,
            input nzcv_t flags, input logic pred, input phys_reg_t dest);
        in_valid      = 1'b1;
        in_op         = op;
        in_pc         = pc;
        in_imm        = imm;
        in_cond       = cond;
        in_flags      = flags;
        in_pred_taken = pred;
        in_dest       = dest;
        while (!in_ready) begin
            saw_full = 1'b1;
            next_cycle();
        end
        next_cycle();
        in_valid = 1'b0;
    endtask

    task automatic send_random();
        logic [31:0] r0;
        logic [31:0] r1;
        logic [31:0] r2;
        logic [31:0] r3;
        r0 = $random(seed);
        r1 = $random(seed);
        r2 = $random(seed);
        r3 = $random(seed);
        send(br_op_t'(r3[23:16] % 8'd3), {r1, r2[31:2], 2'b00}, r0[31:6], r3[3:0],
             r3[7:4], r3[8], r3[15:9]);
    endtask

    task automatic drain();
        int waited;
        stall_mode = 1'b0;
        waited = 0;
        while (exp_q.size() != 0 && waited < 50) begin
            next_cycle();
            waited++;
        end
    endtask

    initial begin : stimulus
        imm_t offsets[4];
        offsets = '{26'd1, 26'h3FFFFFF, 26'h2000000, 26'h1FFFFFF};
        rst_n         = 1'b0;
        in_valid      = 1'b0;
        in_op         = OP_B;
        in_pc         = '0;
        in_imm        = '0;
        in_cond       = '0;
        in_flags      = '0;
        in_pred_taken = 1'b0;
        in_dest       = '0;
        res_ready     = 1'b0;
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        next_cycle();

        if (res_valid !== 1'b0 || in_ready !== 1'b1) begin
            $display("After reset res_valid is %b and in_ready is %b", res_valid, in_ready);
            flow_errors++;
        end

        test_name = "cond_codes";
        for (int c = 0; c < 16; c++) begin
            for (int f = 0; f < 16; f++)
                send(OP_BCOND, pc_t'(32'h4000 + c * 64 + f * 4),
                     imm_t'(c * 16 + f) - imm_t'(100), cond_t'(c), nzcv_t'(f), 1'b0, '0);
        end
        drain();

        test_name = "bl_and_b";
        for (int i = 0; i < 4; i++) begin
            // EQ with Z clear, so a wrong decode would show as not taken
            send(OP_BL, 64'h0000_0080_0000_1000, offsets[i], COND_EQ, 4'b0000, 1'b1,
                 phys_reg_t'(33 + i));
            send(OP_B, 64'h0000_0080_0000_2000, offsets[i], COND_EQ, 4'b0000, 1'b1,
                 phys_reg_t'(40 + i));
        end
        drain();

        test_name = "mispredict";
        for (int i = 0; i < 4; i++)
            send(OP_BCOND, 64'h9000, 26'd16, COND_EQ, i[1] ? 4'b0010 : 4'b0000, i[0], '0);
        drain();

        test_name = "random_free";
        for (int i = 0; i < N_RANDOM; i++)
            send_random();
        drain();

        test_name = "random_stall";
        saw_full   = 1'b0;
        stall_mode = 1'b1;
        for (int i = 0; i < N_RANDOM; i++) begin
            if (($random(seed) & 3) == 0)
                next_cycle();   // Idle gap on the dispatch side
            send_random();
        end
        drain();
        if (!saw_full) begin
            $display("in_ready never fell while the output was stalled");
            flow_errors++;
        end

        if (exp_q.size() != 0) begin
            $display("%0d results were accepted but never came out", exp_q.size());
            flow_errors++;
        end
        $display("Mismatches: %0d, other failures: %0d, results checked: %0d",
                 errors, flow_errors, checked);
        if (errors == 0 && flow_errors == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

//--- project.f
logic/bru_pkg.sv
logic/branch_issue_queue.sv
logic/branch_resolve.sv
logic/branch_result_buffer.sv
logic/branch_unit_top.sv
tb/tb_branch_unit.sv

//--- Makefile
# Verilator build and run of the branch resolution unit testbench
TOP = tb_branch_unit

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing -j 0 --top-module $(TOP) -f project.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "ALL TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
